/* hdl/branchMaskUpdate.sv */
/* Drops a correctly resolved branch from the masks of the dispatching group.
   The result feeds the back-end packets and goes back to the rename
   pipeline register so a stalled group stays current. */
`timescale 1ns/1ps
`default_nettype none

module branchMaskUpdate
  import dispatchPkg::*, packetPkg::*;
(
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      ctrlVerified_i,                // One-cycle strobe.
  input  logic [CheckpointsLog-1:0] ctrlVerifiedId_i,
  input  branchMask_t               branchMask_i [DispatchWidth],
  output branchMask_t               branchMask_o [DispatchWidth]
);

  branchMask_t clearMask;  // One-hot on the verified checkpoint.

  always_comb
  begin
    clearMask = '0;
    if (ctrlVerified_i)
    begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      branchMask_o[lane] = branchMask_i[lane] & ~clearMask;  // Other bits untouched.
    end
  end

  // Every lane must see the resolved branch gone in the same cycle.
  for (genvar g = 0; g < DispatchWidth; g++)
  begin : laneCheck
    verifiedBitClear: assert property (@(posedge clk) disable iff (rst_i)
      ctrlVerified_i |-> !branchMask_o[g][ctrlVerifiedId_i])
      else $error("lane %0d keeps verified checkpoint %0d", g, ctrlVerifiedId_i);
  end

endmodule

`default_nettype wire

/* hdl/dispatch.sv */
/* Dispatch stage of the four-wide core, fully combinational.
   Takes the renamed group, updates branch masks, splits packets for the
   back end and reports whether the group can be written this cycle. */
`timescale 1ns/1ps
`default_nettype none

module dispatch
  import dispatchPkg::*, packetPkg::*;
(
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          renameReady_i,       // Rename holds a valid group.
  input  logic                          flagRecoverEX_i,     // Mispredict recovery.
  input  logic                          ctrlVerified_i,
  input  logic [CheckpointsLog-1:0]     ctrlVerifiedId_i,
  input  renamedPacket_t                renamedPacket_i [DispatchWidth],
  input  logic [LsqCntWidth-1:0]        loadQueueCnt_i,
  input  logic [LsqCntWidth-1:0]        storeQueueCnt_i,
  input  logic [IssueQueueCntWidth-1:0] issueQueueCnt_i,
  input  logic [ActiveListCntWidth-1:0] activeListCnt_i,
  output issuePacket_t                  issuePacket_o [DispatchWidth],
  output activeListPacket_t             alPacket_o [DispatchWidth],
  output lsqPacket_t                    lsqPacket_o [DispatchWidth],
  output branchMask_t                   updatedBranchMask_o [DispatchWidth],  // To rename reg.
  output logic                          backEndReady_o,
  output logic                          stallFrontEnd_o
);

  branchMask_t              renamedMask [DispatchWidth];
  logic [DispatchWidth-1:0] laneLoad;
  logic [DispatchWidth-1:0] laneStore;

  for (genvar g = 0; g < DispatchWidth; g++)
  begin : laneFields
    assign renamedMask[g] = renamedPacket_i[g].branchMask;
    assign laneLoad[g]    = renamedPacket_i[g].isLoad;
    assign laneStore[g]   = renamedPacket_i[g].isStore;
  end

  branchMaskUpdate maskUpdate0 (
    .clk              (clk),
    .rst_i            (rst_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .branchMask_i     (renamedMask),
    .branchMask_o     (updatedBranchMask_o)
  );

  spaceCheck spaceCheck0 (
    .clk              (clk),
    .rst_i            (rst_i),
    .isLoad_i         (laneLoad),
    .isStore_i        (laneStore),
    .loadQueueCnt_i   (loadQueueCnt_i),
    .storeQueueCnt_i  (storeQueueCnt_i),
    .issueQueueCnt_i  (issueQueueCnt_i),
    .activeListCnt_i  (activeListCnt_i),
    .renameReady_i    (renameReady_i),
    .flagRecoverEX_i  (flagRecoverEX_i),
    .backEndReady_o   (backEndReady_o),
    .stallFrontEnd_o  (stallFrontEnd_o)
  );

  // Packets carry the mask with this cycle's verified branch removed.
  packetSplit packetSplit0 (
    .renamedPacket_i  (renamedPacket_i),
    .branchMask_i     (updatedBranchMask_o),
    .issuePacket_o    (issuePacket_o),
    .alPacket_o       (alPacket_o),
    .lsqPacket_o      (lsqPacket_o)
  );

endmodule

`default_nettype wire

/* hdl/dispatchPkg.sv */
/* Machine sizing for the four-wide dispatch stage.
   Register widths, checkpoint count and back-end capacities used by
   every dispatch block and by the packet layouts. */
`default_nettype none

package dispatchPkg;

  // Group shape.
  localparam int DispatchWidth      = 4;    // Lanes dispatched per cycle.

  // Branch checkpoints.
  localparam int Checkpoints        = 8;    // Outstanding branch checkpoints.
  localparam int CheckpointsLog     = 3;    // Checkpoint id width.

  // Register names.
  localparam int PhysRegLog         = 7;    // Physical register tag.
  localparam int LogRegLog          = 5;    // Architectural register number.

  // Instruction fields.
  localparam int PcWidth            = 32;
  localparam int ImmWidth           = 16;
  localparam int OpcodeWidth        = 8;

  // Load and store queues share one size.
  localparam int LsqSize            = 32;
  localparam int LsqCntWidth        = 6;    // Holds 0 to LsqSize.

  // Issue queue.
  localparam int IssueQueueSize     = 32;
  localparam int IssueQueueCntWidth = 6;

  // Active list holds one entry per in-flight instruction.
  localparam int ActiveListSize     = 128;
  localparam int ActiveListCntWidth = 8;

endpackage

`default_nettype wire

/* hdl/packetPkg.sv */
/* Packet layouts exchanged between rename, dispatch and the back end.
   Field order inside each struct is the bit order on the wires, MSB first. */
`default_nettype none

package packetPkg;

  import dispatchPkg::*;

  typedef logic [Checkpoints-1:0] branchMask_t;  // One bit per live checkpoint.

  // Renamed instruction as latched after rename.
  typedef struct packed {
    logic [LogRegLog-1:0]      logDest;
    logic                      destValid;
    logic                      isStore;
    logic                      isLoad;
    branchMask_t               branchMask;     // Unresolved branches ahead of it.
    logic [CheckpointsLog-1:0] checkpointId;
    logic [PhysRegLog-1:0]     src1Phys;
    logic                      src1Valid;
    logic [PhysRegLog-1:0]     src2Phys;
    logic                      src2Valid;
    logic [PhysRegLog-1:0]     destPhys;
    logic [PhysRegLog-1:0]     oldDestPhys;    // Freed at commit.
    logic [ImmWidth-1:0]       immediate;
    logic                      immValid;
    logic [OpcodeWidth-1:0]    opcode;
    logic [PcWidth-1:0]        pc;
  } renamedPacket_t;

  // Issue queue entry; the logical destination stays behind.
  typedef struct packed {
    logic                      destValid;
    logic                      isStore;
    logic                      isLoad;
    branchMask_t               branchMask;     // Already cleared of verified branches.
    logic [CheckpointsLog-1:0] checkpointId;
    logic [PhysRegLog-1:0]     src1Phys;
    logic                      src1Valid;
    logic [PhysRegLog-1:0]     src2Phys;
    logic                      src2Valid;
    logic [PhysRegLog-1:0]     destPhys;
    logic [PhysRegLog-1:0]     oldDestPhys;
    logic [ImmWidth-1:0]       immediate;
    logic                      immValid;
    logic [OpcodeWidth-1:0]    opcode;
    logic [PcWidth-1:0]        pc;
  } issuePacket_t;

  // Active list entry holding what commit needs to retire the instruction.
  typedef struct packed {
    logic                      isLoad;
    logic                      isStore;
    logic [PcWidth-1:0]        pc;
    logic [LogRegLog-1:0]      logDest;
    logic [PhysRegLog-1:0]     destPhys;
    logic [PhysRegLog-1:0]     oldDestPhys;
    logic                      destValid;
  } activeListPacket_t;

  // Load-store queue entry.
  typedef struct packed {
    branchMask_t               branchMask;
    logic                      isStore;
    logic                      isLoad;
  } lsqPacket_t;

endpackage

`default_nettype wire

/* hdl/packetSplit.sv */
/* Cuts each renamed instruction into its issue queue, active list and
   load-store queue entries. The updated branch mask replaces the renamed
   one in the issue and LSQ entries. */
`timescale 1ns/1ps
`default_nettype none

module packetSplit
  import dispatchPkg::*, packetPkg::*;
(
  input  renamedPacket_t    renamedPacket_i [DispatchWidth],
  input  branchMask_t       branchMask_i [DispatchWidth],     // After verify clearing.
  output issuePacket_t      issuePacket_o [DispatchWidth],
  output activeListPacket_t alPacket_o [DispatchWidth],
  output lsqPacket_t        lsqPacket_o [DispatchWidth]
);

  // Issue queue gets everything except the logical destination.
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      issuePacket_o[lane].destValid    = renamedPacket_i[lane].destValid;
      issuePacket_o[lane].isStore      = renamedPacket_i[lane].isStore;
      issuePacket_o[lane].isLoad       = renamedPacket_i[lane].isLoad;
      issuePacket_o[lane].branchMask   = branchMask_i[lane];
      issuePacket_o[lane].checkpointId = renamedPacket_i[lane].checkpointId;
      issuePacket_o[lane].src1Phys     = renamedPacket_i[lane].src1Phys;
      issuePacket_o[lane].src1Valid    = renamedPacket_i[lane].src1Valid;
      issuePacket_o[lane].src2Phys     = renamedPacket_i[lane].src2Phys;
      issuePacket_o[lane].src2Valid    = renamedPacket_i[lane].src2Valid;
      issuePacket_o[lane].destPhys     = renamedPacket_i[lane].destPhys;
      issuePacket_o[lane].oldDestPhys  = renamedPacket_i[lane].oldDestPhys;
      issuePacket_o[lane].immediate    = renamedPacket_i[lane].immediate;
      issuePacket_o[lane].immValid     = renamedPacket_i[lane].immValid;
      issuePacket_o[lane].opcode       = renamedPacket_i[lane].opcode;  // Passed through.
      issuePacket_o[lane].pc           = renamedPacket_i[lane].pc;
    end
  end

  // Commit needs the mapping to restore and the register to free.
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      alPacket_o[lane].isLoad      = renamedPacket_i[lane].isLoad;
      alPacket_o[lane].isStore     = renamedPacket_i[lane].isStore;
      alPacket_o[lane].pc          = renamedPacket_i[lane].pc;
      alPacket_o[lane].logDest     = renamedPacket_i[lane].logDest;
      alPacket_o[lane].destPhys    = renamedPacket_i[lane].destPhys;
      alPacket_o[lane].oldDestPhys = renamedPacket_i[lane].oldDestPhys;
      alPacket_o[lane].destValid   = renamedPacket_i[lane].destValid;
    end
  end

  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      lsqPacket_o[lane].branchMask = branchMask_i[lane];  // Own lane's mask.
      lsqPacket_o[lane].isStore    = renamedPacket_i[lane].isStore;
      lsqPacket_o[lane].isLoad     = renamedPacket_i[lane].isLoad;
    end
  end

endmodule

`default_nettype wire

/* hdl/spaceCheck.sv */
/* Decides whether the whole group fits into the back end this cycle.
   Counts loads and stores in the group and checks load queue, store queue,
   issue queue and active list room; the stall covers all four lanes at once. */
`timescale 1ns/1ps
`default_nettype none

module spaceCheck
  import dispatchPkg::*;
(
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [DispatchWidth-1:0]      isLoad_i,          // Per lane.
  input  logic [DispatchWidth-1:0]      isStore_i,         // Per lane.
  input  logic [LsqCntWidth-1:0]        loadQueueCnt_i,
  input  logic [LsqCntWidth-1:0]        storeQueueCnt_i,
  input  logic [IssueQueueCntWidth-1:0] issueQueueCnt_i,
  input  logic [ActiveListCntWidth-1:0] activeListCnt_i,
  input  logic                          renameReady_i,
  input  logic                          flagRecoverEX_i,
  output logic                          backEndReady_o,
  output logic                          stallFrontEnd_o
);

  logic [LsqCntWidth:0]        loadCnt;     // Loads in the group.
  logic [LsqCntWidth:0]        storeCnt;    // Stores in the group.
  logic [LsqCntWidth:0]        loadSum;
  logic [LsqCntWidth:0]        storeSum;
  logic [IssueQueueCntWidth:0] issueSum;
  logic [ActiveListCntWidth:0] activeSum;
  logic                        loadFull;
  logic                        storeFull;
  logic                        issueFull;
  logic                        activeFull;

  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      loadCnt  = loadCnt + (LsqCntWidth + 1)'(isLoad_i[lane]);
      storeCnt = storeCnt + (LsqCntWidth + 1)'(isStore_i[lane]);
    end
  end

  // Sums carry one extra bit so a full queue plus the group cannot wrap.
  assign loadSum   = {1'b0, loadQueueCnt_i} + loadCnt;
  assign storeSum  = {1'b0, storeQueueCnt_i} + storeCnt;
  assign issueSum  = {1'b0, issueQueueCnt_i}
                   + (IssueQueueCntWidth + 1)'(DispatchWidth);  // Every lane takes a slot.
  assign activeSum = {1'b0, activeListCnt_i}
                   + (ActiveListCntWidth + 1)'(DispatchWidth);

  assign loadFull   = loadSum > (LsqCntWidth + 1)'(LsqSize);
  assign storeFull  = storeSum > (LsqCntWidth + 1)'(LsqSize);
  assign issueFull  = issueSum > (IssueQueueCntWidth + 1)'(IssueQueueSize);
  assign activeFull = activeSum > (ActiveListCntWidth + 1)'(ActiveListSize);

  assign stallFrontEnd_o = loadFull | storeFull | issueFull | activeFull;

  // Rename must have a group and no recovery may be under way.
  assign backEndReady_o = ~stallFrontEnd_o & renameReady_i & ~flagRecoverEX_i;

  // A stalled group must never be written into the back end.
  noWriteOnStall: assert property (@(posedge clk) disable iff (rst_i)
    stallFrontEnd_o |-> !backEndReady_o)
    else $error("back end accepts a group while the front end is stalled");

  // Instructions behind a mispredict are squashed, not dispatched.
  noWriteInRecovery: assert property (@(posedge clk) disable iff (rst_i)
    flagRecoverEX_i |-> !backEndReady_o)
    else $error("back end accepts a group during branch recovery");

endmodule

`default_nettype wire

/* list.f */
hdl/dispatchPkg.sv
hdl/packetPkg.sv
hdl/branchMaskUpdate.sv
hdl/spaceCheck.sv
hdl/packetSplit.sv
hdl/dispatch.sv
tests/dispatchTb.sv

/* run.sh */
#!/bin/sh
# Builds the dispatch testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dispatchTb \
  -f list.f --Mdir obj_dir -o dispatchSim

status=0
./obj_dir/dispatchSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation finished without failures"

/* tests/dispatchTb.sv */
/* Directed and LCG-driven testbench for the combinational dispatch stage.
   Each test drives one group per cycle and compares every DUT output
   against a model built from the dispatch rules, then prints a summary. */
`timescale 1ns/1ps
`default_nettype none

module dispatchTb
  import dispatchPkg::*, packetPkg::*;
();

  localparam int ClockPeriod = 4;
  localparam int ResetCycles = 2;
  localparam int TestVectors = 300;                                  // Upper bound over all tests.
  localparam int WatchdogNs  = (ResetCycles + TestVectors) * ClockPeriod * 2;

  logic                          clk;
  logic                          rst_i;
  logic                          renameReady;
  logic                          flagRecoverEX;
  logic                          ctrlVerified;
  logic [CheckpointsLog-1:0]     ctrlVerifiedId;
  renamedPacket_t                renamedLanes [DispatchWidth];
  logic [LsqCntWidth-1:0]        loadQueueCnt;
  logic [LsqCntWidth-1:0]        storeQueueCnt;
  logic [IssueQueueCntWidth-1:0] issueQueueCnt;
  logic [ActiveListCntWidth-1:0] activeListCnt;
  issuePacket_t                  issuePackets [DispatchWidth];
  activeListPacket_t             alPackets [DispatchWidth];
  lsqPacket_t                    lsqPackets [DispatchWidth];
  branchMask_t                   updatedMasks [DispatchWidth];
  logic                          backEndReady;
  logic                          stallFrontEnd;

  logic [31:0] lcgState = 32'h29a9_c017;
  int          errorCount = 0;
  int          vectorCount = 0;

  dispatch dut0 (
    .clk                 (clk),
    .rst_i               (rst_i),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedPacket_i     (renamedLanes),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .issuePacket_o       (issuePackets),
    .alPacket_o          (alPackets),
    .lsqPacket_o         (lsqPackets),
    .updatedBranchMask_o (updatedMasks),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  always #(ClockPeriod / 2) clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants.
    return lcgState;
  endfunction

  task automatic randomLanes();
    logic [127:0] raw;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      raw = {nextRand(), nextRand(), nextRand(), nextRand()};
      renamedLanes[lane] = raw[$bits(renamedPacket_t)-1:0];
    end
  endtask

  task automatic clearCounts();
    loadQueueCnt  = '0;
    storeQueueCnt = '0;
    issueQueueCnt = '0;
    activeListCnt = '0;
  endtask

  // Drive slot is 1 ns after the rising edge.
  task automatic alignToDrive();
    @(posedge clk);
    #1;
  endtask

  task automatic reportMismatch(input string testName, input string what,
                                input logic [127:0] expValue, input logic [127:0] actValue);
    errorCount++;
    $display("Mismatch in %s: %s expected %h actual %h", testName, what, expValue, actValue);
  endtask

  // Waits to 1 ns before the next edge, then compares all outputs with the model.
  task automatic checkOutputs(input string testName);
    logic [$bits(renamedPacket_t)-1:0] rawLane;
    branchMask_t                       expMask;
    issuePacket_t                      expIssue;
    activeListPacket_t                 expAl;
    lsqPacket_t                        expLsq;
    int                                loads;
    int                                stores;
    logic                              expStall;
    logic                              expReady;
    #2;
    vectorCount++;
    loads  = 0;
    stores = 0;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      expMask = renamedLanes[lane].branchMask;
      if (ctrlVerified)
      begin
        expMask[ctrlVerifiedId] = 1'b0;  // Resolved checkpoint drops out.
      end
      rawLane  = renamedLanes[lane];
      expIssue = rawLane[$bits(issuePacket_t)-1:0];  // Everything below logDest.
      expIssue.branchMask = expMask;
      expAl.isLoad      = renamedLanes[lane].isLoad;
      expAl.isStore     = renamedLanes[lane].isStore;
      expAl.pc          = renamedLanes[lane].pc;
      expAl.logDest     = renamedLanes[lane].logDest;
      expAl.destPhys    = renamedLanes[lane].destPhys;
      expAl.oldDestPhys = renamedLanes[lane].oldDestPhys;
      expAl.destValid   = renamedLanes[lane].destValid;
      expLsq = {expMask, renamedLanes[lane].isStore, renamedLanes[lane].isLoad};
      loads  = loads + int'(renamedLanes[lane].isLoad);
      stores = stores + int'(renamedLanes[lane].isStore);
      if (updatedMasks[lane] !== expMask)
        reportMismatch(testName, $sformatf("updated mask lane %0d", lane),
                       128'(expMask), 128'(updatedMasks[lane]));
      if (issuePackets[lane] !== expIssue)
        reportMismatch(testName, $sformatf("issue packet lane %0d", lane),
                       128'(expIssue), 128'(issuePackets[lane]));
      if (alPackets[lane] !== expAl)
        reportMismatch(testName, $sformatf("active list packet lane %0d", lane),
                       128'(expAl), 128'(alPackets[lane]));
      if (lsqPackets[lane] !== expLsq)
        reportMismatch(testName, $sformatf("LSQ packet lane %0d", lane),
                       128'(expLsq), 128'(lsqPackets[lane]));
    end
    expStall = (int'(loadQueueCnt) + loads > LsqSize)
            || (int'(storeQueueCnt) + stores > LsqSize)
            || (int'(issueQueueCnt) + DispatchWidth > IssueQueueSize)
            || (int'(activeListCnt) + DispatchWidth > ActiveListSize);
    expReady = !expStall && renameReady && !flagRecoverEX;
    if (stallFrontEnd !== expStall)
      reportMismatch(testName, "stallFrontEnd", 128'(expStall), 128'(stallFrontEnd));
    if (backEndReady !== expReady)
      reportMismatch(testName, "backEndReady", 128'(expReady), 128'(backEndReady));
  endtask

  task automatic passThroughTest();
    for (int v = 0; v < 20; v++)
    begin
      alignToDrive();
      randomLanes();
      ctrlVerified = 1'b0;
      checkOutputs("passThrough");
    end
  endtask

  // Each id gets a strobe cycle followed by a quiet cycle.
  task automatic branchMaskTest();
    for (int id = 0; id < Checkpoints; id++)
    begin
      alignToDrive();
      randomLanes();
      for (int lane = 0; lane < DispatchWidth; lane++)
        renamedLanes[lane].branchMask[id] = 1'b1;  // Make the clear visible.
      ctrlVerified   = 1'b1;
      ctrlVerifiedId = CheckpointsLog'(id);
      checkOutputs("branchMask");
      alignToDrive();
      ctrlVerified = 1'b0;
      checkOutputs("branchMaskIdle");
    end
  endtask

  task automatic lsqPacketTest();
    for (int k = 0; k < 2 * DispatchWidth; k++)
    begin
      alignToDrive();
      randomLanes();
      for (int lane = 0; lane < DispatchWidth; lane++)
      begin
        renamedLanes[lane].isLoad  = (k < DispatchWidth) && (lane == k);
        renamedLanes[lane].isStore = (lane == (k + 2) % DispatchWidth);
      end
      checkOutputs("lsqPacket");
    end
  endtask

  task automatic capacityTest();
    for (int n = 0; n <= DispatchWidth; n++)
    begin
      for (int extra = 0; extra < 2; extra++)
      begin
        alignToDrive();
        randomLanes();
        clearCounts();
        for (int lane = 0; lane < DispatchWidth; lane++)
          renamedLanes[lane].isLoad = (lane < n);
        loadQueueCnt = LsqCntWidth'(LsqSize - n + extra);  // Limit, then one past.
        checkOutputs("loadCapacity");
        alignToDrive();
        randomLanes();
        clearCounts();
        for (int lane = 0; lane < DispatchWidth; lane++)
          renamedLanes[lane].isStore = (lane < n);
        storeQueueCnt = LsqCntWidth'(LsqSize - n + extra);
        checkOutputs("storeCapacity");
      end
    end
    for (int extra = 0; extra < 2; extra++)
    begin
      alignToDrive();
      clearCounts();
      issueQueueCnt = IssueQueueCntWidth'(IssueQueueSize - DispatchWidth + extra);
      checkOutputs("issueCapacity");
      alignToDrive();
      clearCounts();
      activeListCnt = ActiveListCntWidth'(ActiveListSize - DispatchWidth + extra);
      checkOutputs("activeListCapacity");
    end
  endtask

  task automatic readinessTest();
    for (int mode = 0; mode < 5; mode++)
    begin
      alignToDrive();
      randomLanes();
      clearCounts();
      renameReady   = (mode == 1) || (mode == 4);
      flagRecoverEX = (mode == 1) || (mode == 3);
      if (mode >= 2 && mode <= 3)
        issueQueueCnt = IssueQueueCntWidth'(IssueQueueSize);  // Forces a stall.
      checkOutputs("readiness");
    end
  endtask

  task automatic randomSweep();
    logic [31:0] r;
    for (int v = 0; v < 200; v++)
    begin
      alignToDrive();
      randomLanes();
      r = nextRand();
      ctrlVerified   = r[0];
      ctrlVerifiedId = r[3:1];
      renameReady    = r[4] | r[5];
      flagRecoverEX  = r[6] & r[7];
      loadQueueCnt   = LsqCntWidth'(nextRand() % (LsqSize + 2));
      storeQueueCnt  = LsqCntWidth'(nextRand() % (LsqSize + 2));
      issueQueueCnt  = IssueQueueCntWidth'(nextRand() % (IssueQueueSize + 2));
      activeListCnt  = ActiveListCntWidth'(nextRand() % (ActiveListSize + 2));
      checkOutputs("randomSweep");
    end
  endtask

  initial
  begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns before the tests finished", WatchdogNs);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    clk            = 1'b0;
    rst_i          = 1'b1;
    renameReady    = 1'b0;
    flagRecoverEX  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    clearCounts();
    for (int lane = 0; lane < DispatchWidth; lane++)
      renamedLanes[lane] = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_i       = 1'b0;
    renameReady = 1'b1;
    passThroughTest();
    branchMaskTest();
    lsqPacketTest();
    capacityTest();
    readinessTest();
    randomSweep();
    $display("Vectors checked: %0d, errors: %0d", vectorCount, errorCount);
    if (errorCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
